//--- files.f
verilog/isaPkg.sv
verilog/ucodePkg.sv
verilog/flowSequencer.sv
verilog/programCounters.sv
verilog/ucodeStore.sv
verilog/registerFile.sv
verilog/uopExecute.sv
verilog/cpuCore.sv
test/busMemory.sv
test/cpuCoreTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module cpuCoreTb -f files.f
./obj_dir/VcpuCoreTb

//--- test/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;
	import ucodePkg::*;

	localparam logic [15:0] resetPc = 16'h0100;
	localparam int clockPeriod = 100;
	localparam int resetCycles = 5;
	localparam int numRows = 8;
	localparam int maxRowBytes = 24;
	localparam int longestFlow = 6;       // JP nn
	localparam int maxInstrPerRow = 64;   // The DEC BC loop is the longest row
	localparam int quietCycles = 40;
	localparam int watchdogCycles = resetCycles + quietCycles + 100
		+ numRows * maxInstrPerRow * (longestFlow + 2);

	// Register fields of the opcode map
	localparam logic [2:0] fieldB = 3'd0;
	localparam logic [2:0] fieldC = 3'd1;
	localparam logic [2:0] fieldD = 3'd2;
	localparam logic [2:0] fieldE = 3'd3;
	localparam logic [2:0] fieldA = 3'd7;

	logic        iClock;
	logic        arstN;
	logic [7:0]  readData;
	busRequest   bus;

	logic [7:0]  rowBytes [numRows][maxRowBytes];
	int          rowLength [numRows];
	logic [15:0] rowAddr [numRows];
	logic [7:0]  rowData [numRows];
	int          curRow;
	logic [15:0] buildPc;
	logic [15:0] lfsrState;

	cpuCore #(.resetPc(resetPc)) cpuCore_inst
	(
		.iClock(iClock),
		.arstN(arstN),
		.readData(readData),
		.bus(bus)
	);

	busMemory busMemory_inst
	(
		.iClock(iClock),
		.bus(bus),
		.readData(readData)
	);

	initial iClock = 1'b0;
	always #(clockPeriod / 2) iClock = ~iClock;

	// --------------------------------------------------
	// Random source and checking

	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		if (state[0])
			lfsrNext = (state >> 1) ^ 16'hB400;   // Taps 16, 14, 13, 11
		else
			lfsrNext = state >> 1;
	endfunction

	task automatic drawBits(input int count, output logic [7:0] value);
		int i;
		value = 8'h00;
		for (i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	task automatic randomAddress(input logic [7:0] page, output logic [15:0] addr);
		logic [7:0] low;
		drawBits(8, low);
		addr = {page, low};
	endtask

	task automatic checkEqual(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("FAIL at time %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// --------------------------------------------------
	// Program image, one row per expected write

	task automatic appendByte(input logic [7:0] value);
		rowBytes[curRow][rowLength[curRow]] = value;
		rowLength[curRow] = rowLength[curRow] + 1;
		buildPc = buildPc + 16'd1;
	endtask

	task automatic appendWord(input logic [15:0] value);
		appendByte(value[7:0]);   // Low byte first
		appendByte(value[15:8]);
	endtask

	task automatic loadImmediate(input logic [2:0] field, input logic [7:0] value);
		appendByte({2'b00, field, 3'b110});
		appendByte(value);
	endtask

	task automatic loadHlPair(input logic [15:0] value);
		appendByte(8'h21);
		appendWord(value);
	endtask

	task automatic copyRegister(input logic [2:0] dst, input logic [2:0] src);
		appendByte({2'b01, dst, src});
	endtask

	task automatic storeAToHl();
		appendByte(8'h77);
	endtask

	task automatic jumpAbsolute(input logic [15:0] target);
		appendByte(8'hC3);
		appendWord(target);
	endtask

	task automatic expectWrite(input logic [15:0] addr, input logic [7:0] data);
		rowAddr[curRow] = addr;
		rowData[curRow] = data;
		curRow = curRow + 1;
	endtask

	// BIT b,D picks one of two markers through JR NZ
	task automatic bitBranchRow(input logic [7:0] page, input logic [7:0] value,
		input logic [2:0] bitSel);
		logic [15:0] addr;
		randomAddress(page, addr);
		loadHlPair(addr);
		loadImmediate(fieldD, value);
		appendByte(8'hCB);
		appendByte({2'b01, bitSel, fieldD});
		appendByte(8'h20);
		appendByte(8'h06);   // Over the bit-clear marker and its JP
		loadImmediate(fieldA, 8'h5A);
		storeAToHl();
		jumpAbsolute(buildPc + 16'd6);
		loadImmediate(fieldA, 8'hA5);
		storeAToHl();
		expectWrite(addr, value[bitSel] ? 8'hA5 : 8'h5A);   // Set bit clears Z and jumps
	endtask

	task automatic buildProgram();
		logic [15:0] addr;
		logic [15:0] loopStart;
		logic [15:0] offset;
		logic [7:0]  first;
		logic [7:0]  second;
		logic [7:0]  count;
		logic [7:0]  bitSel;
		int          i;
		curRow = 0;
		buildPc = resetPc;
		for (i = 0; i < numRows; i++)
			rowLength[i] = 0;

		// NOP, then an immediate passed through C, E and A
		randomAddress(8'hC0, addr);
		drawBits(8, first);
		appendByte(8'h00);
		loadHlPair(addr);
		loadImmediate(fieldC, first);
		copyRegister(fieldE, fieldC);
		copyRegister(fieldA, fieldE);
		storeAToHl();
		expectWrite(addr, first);

		randomAddress(8'hC1, addr);
		drawBits(8, first);
		drawBits(8, second);
		loadHlPair(addr);
		loadImmediate(fieldA, first);
		loadImmediate(fieldD, second);
		appendByte({5'b10100, fieldD});   // AND D
		storeAToHl();
		expectWrite(addr, first & second);

		randomAddress(8'hC2, addr);
		drawBits(8, first);
		drawBits(8, second);
		loadHlPair(addr);
		loadImmediate(fieldA, first);
		loadImmediate(fieldB, second);
		appendByte({5'b10101, fieldB});   // XOR B
		storeAToHl();
		expectWrite(addr, first ^ second);

		randomAddress(8'hC3, addr);
		drawBits(8, first);
		loadHlPair(addr);
		loadImmediate(fieldA, first);
		appendByte(8'h23);
		storeAToHl();
		expectWrite(addr + 16'd1, first);

		// HL advances once per pass, so the store address carries the count
		randomAddress(8'hC5, addr);
		drawBits(4, count);
		count = count + 8'd1;
		loadHlPair(addr);
		loadImmediate(fieldB, 8'h00);
		loadImmediate(fieldC, count);
		loopStart = buildPc;
		appendByte(8'h23);
		appendByte(8'h0B);
		appendByte(8'h20);
		offset = loopStart - (buildPc + 16'd1);
		appendByte(offset[7:0]);
		copyRegister(fieldA, fieldC);
		storeAToHl();
		expectWrite(addr + {8'h00, count}, 8'h00);   // BC has run down to zero

		drawBits(8, first);
		drawBits(3, bitSel);
		bitBranchRow(8'hC6, first, bitSel[2:0]);
		bitBranchRow(8'hC7, ~first, bitSel[2:0]);   // Same bit, other branch

		randomAddress(8'hC8, addr);
		drawBits(8, first);
		loadHlPair(addr);
		loadImmediate(fieldA, first);
		jumpAbsolute(buildPc + 16'd6);
		loadImmediate(fieldA, 8'hEE);   // Skipped block
		storeAToHl();
		storeAToHl();
		expectWrite(addr, first);
	endtask

	task automatic writeImage();
		logic [15:0] addr;
		int          i;
		int          row;
		int          idx;
		for (i = 0; i < 65536; i++)
		begin
			addr = i[15:0];
			busMemory_inst.mem[addr] = addr[15:8] ^ addr[7:0] ^ 8'h3C;
		end
		addr = resetPc;
		for (row = 0; row < numRows; row++)
		begin
			for (idx = 0; idx < rowLength[row]; idx++)
			begin
				busMemory_inst.mem[addr] = rowBytes[row][idx];
				addr = addr + 16'd1;
			end
		end
		// The core parks in a jump to itself
		busMemory_inst.mem[addr] = 8'hC3;
		busMemory_inst.mem[addr + 16'd1] = addr[7:0];
		busMemory_inst.mem[addr + 16'd2] = addr[15:8];
	endtask

	task automatic waitForWrite();
		@(negedge iClock);
		while (!bus.writeEnable)
			@(negedge iClock);
	endtask

	// --------------------------------------------------
	// Run

	initial
	begin
		int row;
		arstN = 1'b0;
		lfsrState = 16'd19;
		buildProgram();
		writeImage();

		repeat (resetCycles)
		begin
			@(negedge iClock);
			checkEqual("bus.writeEnable", 16'd0, {15'd0, bus.writeEnable});
			checkEqual("bus.addr", resetPc, bus.addr);
		end
		arstN = 1'b1;
		@(negedge iClock);
		checkEqual("bus.addr", resetPc, bus.addr);   // First fetch
		checkEqual("bus.writeEnable", 16'd0, {15'd0, bus.writeEnable});

		for (row = 0; row < numRows; row++)
		begin
			waitForWrite();
			checkEqual("bus.addr", rowAddr[row], bus.addr);
			checkEqual("bus.writeData", {8'h00, rowData[row]}, {8'h00, bus.writeData});
		end

		// Parked core, no further traffic
		repeat (quietCycles)
		begin
			@(negedge iClock);
			checkEqual("bus.writeEnable", 16'd0, {15'd0, bus.writeEnable});
		end
		$display("*** PASSED ***");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("Timeout after %0d cycles, the program stalled before its last write",
			watchdogCycles);
		$display("*** FAILED ***");
		$fatal(1, "Watchdog timeout");
	end

endmodule

//--- test/busMemory.sv
`timescale 1ns/1ps

module busMemory
(
	input  logic                iClock,
	input  ucodePkg::busRequest bus,
	output logic [7:0]          readData
);

	// Whole 64 KiB space, the testbench fills it and places the program image
	logic [7:0] mem [0:65535];

	assign readData = mem[bus.addr];   // Reads answer within the same cycle

	// Store on the rising edge that sees the strobe
	always @(posedge iClock)
	begin
		if (bus.writeEnable)
			mem[bus.addr] <= bus.writeData;
	end

endmodule

//--- verilog/cpuCore.sv
`timescale 1ns/1ps

module cpuCore
#(
	parameter logic [15:0] resetPc = 16'h0000
)
(
	input  logic                iClock,
	input  logic                arstN,
	input  logic [7:0]          readData,
	output ucodePkg::busRequest bus
);
	import isaPkg::*;
	import ucodePkg::*;

	// Sequencing
	logic        flowStart, flowRun, flowEnd;
	logic [7:0]  microPc;
	logic [7:0]  dispatchIdx;
	logic [15:0] pc;
	uopWord      uop;

	// Execution
	regWriteReq  regWrite;
	regView      view;
	regCode      readSel;
	flagBits     flagsIn;
	logic        flagWrite, addrLoad, writeEnable, loadPc, cbDispatch;
	logic [15:0] newPc;
	logic [15:0] addr;
	logic [7:0]  writeByte;

	flowSequencer flowSequencer_inst
	(
		.*
	);

	programCounters #(.resetPc(resetPc)) programCounters_inst
	(
		.incPc(uop.incPc),
		.*
	);

	ucodeStore ucodeStore_inst
	(
		.opcode(readData),   // The dispatch byte comes straight off the bus
		.*
	);

	registerFile registerFile_inst
	(
		.addrSel(uop.operand),
		.*
	);

	uopExecute uopExecute_inst
	(
		.*
	);

	assign bus = '{addr: addr, writeData: writeByte, writeEnable: writeEnable};

endmodule

//--- verilog/uopExecute.sv
`timescale 1ns/1ps

module uopExecute
(
	input  ucodePkg::uopWord     uop,
	input  logic [7:0]           readData,
	input  logic                 flowRun,
	input  ucodePkg::regView     view,
	output isaPkg::regCode       readSel,
	output ucodePkg::regWriteReq regWrite,
	output logic                 flagWrite,
	output isaPkg::flagBits      flagsIn,
	output logic                 addrLoad,
	output logic                 writeEnable,
	output logic                 loadPc,
	output logic [15:0]          newPc,
	output logic                 cbDispatch,
	output logic                 flowEnd
);
	import isaPkg::*;
	import ucodePkg::*;

	opcodeWord   op;
	regCode      dstSel;
	logic [15:0] result;
	logic [7:0]  operandByte;
	logic [7:0]  bitMask;
	logic        halfFlag;
	logic        wantWrite, wantFlags, wantAddr, wantMem, wantPc, wantCb;

	assign op = readData;   // Opcode or CB operand, depending on the flow
	assign operandByte = view.readValue[7:0];
	assign bitMask = 8'h01 << op.cb.bitIndex;

	// --------------------------------------------------
	// Micro-op decode
	always_comb
	begin
		readSel = uop.operand;
		dstSel = uop.operand;
		result = 16'h0000;
		halfFlag = 1'b0;
		wantWrite = 1'b0;
		wantFlags = 1'b0;
		wantAddr = 1'b0;
		wantMem = 1'b0;
		wantPc = 1'b0;
		wantCb = 1'b0;
		case (uop.cmd)
			sma:
				wantAddr = 1'b1;
			srm:
			begin
				wantWrite = 1'b1;
				result = {8'h00, readData};
			end
			smw:
				wantMem = 1'b1;   // Data is the low byte of the operand register
			inc16, dec16:
			begin
				wantWrite = 1'b1;
				wantFlags = 1'b1;
				result = (uop.cmd == inc16) ? view.readValue + 16'd1 : view.readValue - 16'd1;
			end
			addx16:
			begin
				dstSel = codeX16;
				wantWrite = 1'b1;
				result = view.x16 + {{8{operandByte[7]}}, operandByte};
			end
			spc:
			begin
				wantPc = 1'b1;
				result = view.readValue;
			end
			jcb:
				wantCb = 1'b1;
			srx8:
			begin
				wantWrite = 1'b1;
				result = {8'h00, view.x8};
			end
			srx16:
			begin
				wantWrite = 1'b1;
				result = view.x16;
			end
			aluOp:
			begin
				readSel = regCode'({1'b0, op.main.src});
				if (op.main.group == 2'b01)
				begin
					dstSel = regCode'({1'b0, op.main.dst});   // LD r,r'
					wantWrite = 1'b1;
					result = {8'h00, operandByte};
				end
				else if (op.main.group == 2'b10)
				begin
					dstSel = codeA;
					wantWrite = 1'b1;
					wantFlags = 1'b1;
					halfFlag = (op.main.dst == 3'd4);   // AND sets H, XOR clears it
					if (op.main.dst == 3'd4)
						result = {8'h00, view.a & operandByte};
					else
						result = {8'h00, view.a ^ operandByte};
				end
			end
			bitTest:
			begin
				readSel = regCode'({1'b0, op.cb.target});
				wantFlags = 1'b1;
				halfFlag = 1'b1;
				result = {8'h00, operandByte & bitMask};   // Z reports a clear bit
			end
			sx8r:
			begin
				dstSel = codeX8;
				wantWrite = 1'b1;
				result = {8'h00, operandByte};
			end
			sx16r:
			begin
				dstSel = codeX16;
				wantWrite = 1'b1;
				result = view.readValue;
			end
			default:
				wantWrite = 1'b0;
		endcase
	end

	// Flow end rule against the stored flags
	always_comb
	begin
		case (uop.endRule)
			endAlways:    flowEnd = 1'b1;
			endIfZero:    flowEnd = view.flags.z;
			endIfNotZero: flowEnd = !view.flags.z;
			default:      flowEnd = 1'b0;
		endcase
	end

	// --------------------------------------------------
	// Outputs act only while a flow runs
	assign regWrite = '{enable: flowRun & wantWrite, target: dstSel, data: result};
	assign flagsIn = '{z: (result == 16'h0000), n: result[15], h: halfFlag,
		c: view.flags.c, spare: view.flags.spare};
	assign flagWrite = flowRun & wantFlags;
	assign addrLoad = flowRun & wantAddr;
	assign writeEnable = flowRun & wantMem;
	assign loadPc = flowRun & wantPc;
	assign newPc = result;
	assign cbDispatch = flowRun & wantCb;

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile
(
	input  logic                 iClock,
	input  logic                 arstN,
	input  ucodePkg::regWriteReq regWrite,
	input  isaPkg::regCode       readSel,
	input  logic                 addrLoad,
	input  isaPkg::regCode       addrSel,
	input  logic                 flagWrite,
	input  isaPkg::flagBits      flagsIn,
	input  logic [15:0]          pc,
	output ucodePkg::regView     view,
	output logic [15:0]          addr,
	output logic [7:0]           writeByte
);
	import isaPkg::*;
	import ucodePkg::*;

	logic [7:0]  regB, regC, regD, regE, regH, regL, regA;
	logic [7:0]  regSpL, regSpH, regX8;
	logic [15:0] regX16;
	flagBits     flags;
	regCode      curAddrSel;
	logic [10:0] byteEn;        // {X16, X8, SPH, SPL, A, L, H, E, D, C, B}
	logic        pairWrite;
	logic [7:0]  hiByte;
	logic [15:0] readValue;

	function automatic logic [15:0] regValue(input regCode sel);
		case (sel)
			codeB:   regValue = {8'h00, regB};
			codeC:   regValue = {8'h00, regC};
			codeD:   regValue = {8'h00, regD};
			codeE:   regValue = {8'h00, regE};
			codeH:   regValue = {8'h00, regH};
			codeL:   regValue = {8'h00, regL};
			codeHl:  regValue = {regH, regL};
			codeA:   regValue = {8'h00, regA};
			codePc:  regValue = pc;
			codeSp:  regValue = {regSpH, regSpL};
			codeX8:  regValue = {8'h00, regX8};
			codeX16: regValue = regX16;
			codeBc:  regValue = {regB, regC};
			codeIoc: regValue = {8'hFF, regC};
			codeDe:  regValue = {regD, regE};
			default: regValue = 16'h0000;
		endcase
	endfunction

	// --------------------------------------------------
	// Write decode
	assign pairWrite = regWrite.target inside {codeBc, codeDe, codeHl, codeSp};
	assign hiByte = pairWrite ? regWrite.data[15:8] : regWrite.data[7:0];   // For B, D, H, SPH

	always_comb
	begin
		byteEn = 11'h000;
		if (regWrite.enable)
		begin
			case (regWrite.target)
				codeB:   byteEn = 11'h001;
				codeC:   byteEn = 11'h002;
				codeD:   byteEn = 11'h004;
				codeE:   byteEn = 11'h008;
				codeH:   byteEn = 11'h010;
				codeL:   byteEn = 11'h020;
				codeA:   byteEn = 11'h040;
				codeX8:  byteEn = 11'h200;
				codeX16: byteEn = 11'h400;
				codeBc:  byteEn = 11'h003;
				codeDe:  byteEn = 11'h00C;
				codeHl:  byteEn = 11'h030;
				codeSp:  byteEn = 11'h180;
				default: byteEn = 11'h000;   // PC, IOC and NONE are not writable here
			endcase
		end
	end

	always_ff @(posedge iClock)
	begin
		if (byteEn[0]) regB <= hiByte;
		if (byteEn[1]) regC <= regWrite.data[7:0];
		if (byteEn[2]) regD <= hiByte;
		if (byteEn[3]) regE <= regWrite.data[7:0];
		if (byteEn[4]) regH <= hiByte;
		if (byteEn[5]) regL <= regWrite.data[7:0];
		if (byteEn[6]) regA <= regWrite.data[7:0];
		if (byteEn[7]) regSpL <= regWrite.data[7:0];
		if (byteEn[8]) regSpH <= hiByte;
		if (byteEn[9]) regX8 <= regWrite.data[7:0];
		if (byteEn[10]) regX16 <= regWrite.data;
	end

	always_ff @(posedge iClock or negedge arstN)
	begin
		if (!arstN)
		begin
			flags <= '0;
			curAddrSel <= codePc;   // Fetch starts from the program counter
		end
		else
		begin
			if (flagWrite)
				flags <= flagsIn;
			if (addrLoad)
				curAddrSel <= addrSel;
		end
	end

	// --------------------------------------------------
	// Read side
	always_comb readValue = regValue(readSel);
	always_comb addr = regValue(curAddrSel);

	assign writeByte = readValue[7:0];
	assign view = '{readValue: readValue, a: regA, x8: regX8, x16: regX16, flags: flags};

endmodule

//--- verilog/ucodeStore.sv
`timescale 1ns/1ps

module ucodeStore
(
	input  logic [7:0]        microPc,
	input  isaPkg::opcodeWord opcode,
	input  logic              cbDispatch,
	output ucodePkg::uopWord  uop,
	output logic [7:0]        dispatchIdx
);
	import isaPkg::*;
	import ucodePkg::*;

	// Flow entry points
	localparam logic [7:0] flowNop    = 8'd0;
	localparam logic [7:0] flowAlu    = 8'd1;    // LD r,r', AND r, XOR r
	localparam logic [7:0] flowLdRn   = 8'd2;    // Seven two-step flows, B first
	localparam logic [7:0] flowLdHlnn = 8'd16;
	localparam logic [7:0] flowStHlA  = 8'd19;
	localparam logic [7:0] flowIncHl  = 8'd22;
	localparam logic [7:0] flowDecBc  = 8'd23;
	localparam logic [7:0] flowJp     = 8'd24;
	localparam logic [7:0] flowJrNz   = 8'd30;
	localparam logic [7:0] flowCb     = 8'd35;
	localparam logic [7:0] flowBit    = 8'd37;

	logic isRegLoad;
	logic isLogicOp;

	function automatic uopWord uopOf
	(
		input logic   incPc,
		input endCond endRule,
		input uopCmd  cmd,
		input regCode operand
	);
		uopOf = '{incPc: incPc, endRule: endRule, cmd: cmd, operand: operand};
	endfunction

	// --------------------------------------------------
	// Microcode ROM
	always_comb
	begin
		case (microPc)
			flowNop:            uop = uopOf(1'b1, endAlways, nop, codeNone);
			flowAlu:            uop = uopOf(1'b1, endAlways, aluOp, codeNone);
			flowLdRn:           uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd1:    uop = uopOf(1'b1, endAlways, srm, codeB);
			flowLdRn + 8'd2:    uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd3:    uop = uopOf(1'b1, endAlways, srm, codeC);
			flowLdRn + 8'd4:    uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd5:    uop = uopOf(1'b1, endAlways, srm, codeD);
			flowLdRn + 8'd6:    uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd7:    uop = uopOf(1'b1, endAlways, srm, codeE);
			flowLdRn + 8'd8:    uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd9:    uop = uopOf(1'b1, endAlways, srm, codeH);
			flowLdRn + 8'd10:   uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd11:   uop = uopOf(1'b1, endAlways, srm, codeL);
			flowLdRn + 8'd12:   uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdRn + 8'd13:   uop = uopOf(1'b1, endAlways, srm, codeA);
			flowLdHlnn:         uop = uopOf(1'b1, endNever, nop, codeNone);
			flowLdHlnn + 8'd1:  uop = uopOf(1'b1, endNever, srm, codeL);   // Low byte first
			flowLdHlnn + 8'd2:  uop = uopOf(1'b1, endAlways, srm, codeH);
			flowStHlA:          uop = uopOf(1'b0, endNever, sma, codeHl);
			flowStHlA + 8'd1:   uop = uopOf(1'b0, endNever, smw, codeA);
			flowStHlA + 8'd2:   uop = uopOf(1'b1, endAlways, sma, codePc);
			flowIncHl:          uop = uopOf(1'b1, endAlways, inc16, codeHl);
			flowDecBc:          uop = uopOf(1'b1, endAlways, dec16, codeBc);
			// JP nn borrows HL for the target and restores it from X16
			flowJp:             uop = uopOf(1'b1, endNever, nop, codeNone);
			flowJp + 8'd1:      uop = uopOf(1'b0, endNever, sx16r, codeHl);
			flowJp + 8'd2:      uop = uopOf(1'b1, endNever, srm, codeL);
			flowJp + 8'd3:      uop = uopOf(1'b0, endNever, srm, codeH);
			flowJp + 8'd4:      uop = uopOf(1'b0, endNever, spc, codeHl);
			flowJp + 8'd5:      uop = uopOf(1'b0, endAlways, srx16, codeHl);
			flowJrNz:           uop = uopOf(1'b1, endNever, nop, codeNone);
			flowJrNz + 8'd1:    uop = uopOf(1'b1, endIfZero, srm, codeX8);   // Falls through on Z
			flowJrNz + 8'd2:    uop = uopOf(1'b0, endNever, sx16r, codePc);
			flowJrNz + 8'd3:    uop = uopOf(1'b0, endNever, addx16, codeX8);
			flowJrNz + 8'd4:    uop = uopOf(1'b0, endAlways, spc, codeX16);
			flowCb:             uop = uopOf(1'b1, endNever, nop, codeNone);
			flowCb + 8'd1:      uop = uopOf(1'b0, endNever, jcb, codeNone);
			flowBit:            uop = uopOf(1'b1, endAlways, bitTest, codeNone);
			default:            uop = uopOf(1'b0, endAlways, nop, codeNone);
		endcase
	end

	// --------------------------------------------------
	// Dispatch tables
	assign isRegLoad = (opcode.main.group == 2'b01) && (opcode.main.dst != 3'd6)
		&& (opcode.main.src != 3'd6);
	assign isLogicOp = (opcode.main.group == 2'b10) && (opcode.main.src != 3'd6)
		&& ((opcode.main.dst == 3'd4) || (opcode.main.dst == 3'd5));

	always_comb
	begin
		if (cbDispatch)
		begin
			if ((opcode.cb.cbOp == 2'b01) && (opcode.cb.target != 3'd6))
				dispatchIdx = flowBit;
			else
				dispatchIdx = flowNop;   // Skips the operand byte
		end
		else
		begin
			case (opcode)
				8'h06:   dispatchIdx = flowLdRn;
				8'h0E:   dispatchIdx = flowLdRn + 8'd2;
				8'h16:   dispatchIdx = flowLdRn + 8'd4;
				8'h1E:   dispatchIdx = flowLdRn + 8'd6;
				8'h26:   dispatchIdx = flowLdRn + 8'd8;
				8'h2E:   dispatchIdx = flowLdRn + 8'd10;
				8'h3E:   dispatchIdx = flowLdRn + 8'd12;
				8'h21:   dispatchIdx = flowLdHlnn;
				8'h77:   dispatchIdx = flowStHlA;
				8'h23:   dispatchIdx = flowIncHl;
				8'h0B:   dispatchIdx = flowDecBc;
				8'hC3:   dispatchIdx = flowJp;
				8'h20:   dispatchIdx = flowJrNz;
				8'hCB:   dispatchIdx = flowCb;
				default: dispatchIdx = (isRegLoad || isLogicOp) ? flowAlu : flowNop;
			endcase
		end
	end

endmodule

//--- verilog/programCounters.sv
`timescale 1ns/1ps

module programCounters
#(
	parameter logic [15:0] resetPc = 16'h0000
)
(
	input  logic        iClock,
	input  logic        arstN,
	input  logic        flowStart,
	input  logic        flowRun,
	input  logic        incPc,
	input  logic        cbDispatch,
	input  logic        loadPc,
	input  logic [7:0]  dispatchIdx,
	input  logic [15:0] newPc,
	output logic [7:0]  microPc,
	output logic [15:0] pc
);

	// Micro-program counter
	always_ff @(posedge iClock or negedge arstN)
	begin
		if (!arstN)
			microPc <= 8'h00;
		else if (flowStart || cbDispatch)
			microPc <= dispatchIdx;   // Entry of a new flow or of the CB flow
		else if (flowRun)
			microPc <= microPc + 8'd1;
	end

	// Instruction program counter
	always_ff @(posedge iClock or negedge arstN)
	begin
		if (!arstN)
		begin
			pc <= resetPc;
		end
		else if (loadPc)
		begin
			pc <= newPc;   // Jumps take priority over the step
		end
		else if (flowRun && incPc)
		begin
			pc <= pc + 16'd1;
		end
	end

endmodule

//--- verilog/flowSequencer.sv
`timescale 1ns/1ps

module flowSequencer
(
	input  logic iClock,
	input  logic arstN,
	input  logic flowEnd,
	output logic flowStart,
	output logic flowRun
);
	import ucodePkg::*;

	seqState state;
	seqState nextState;

	always_ff @(posedge iClock or negedge arstN)
	begin
		if (!arstN)
			state <= afterReset;
		else
			state <= nextState;
	end

	// --------------------------------------------------
	// One pass per instruction: dispatch, run, one idle cycle
	always_comb
	begin
		case (state)
			afterReset:
				nextState = startFlow;
			startFlow:
				nextState = runFlow;   // Micro-PC takes the dispatch index here
			runFlow:
			begin
				if (flowEnd)
					nextState = endFlow;
				else
					nextState = runFlow;
			end
			endFlow:
				nextState = startFlow;
			default:
				nextState = afterReset;
		endcase
	end

	assign flowStart = (state == startFlow);
	assign flowRun = (state == runFlow);   // Gates every write in the core

endmodule

//--- verilog/ucodePkg.sv
package ucodePkg;

	typedef enum logic [4:0]
	{
		nop     = 5'd0,
		sma     = 5'd1,    // Latch the bus address source
		srm     = 5'd2,    // Register from the byte on the bus
		smw     = 5'd3,    // One-cycle memory write
		inc16   = 5'd4,
		dec16   = 5'd5,
		addx16  = 5'd6,    // X16 plus a sign-extended byte
		spc     = 5'd7,    // Load the program counter
		jcb     = 5'd8,    // Redispatch through the CB table
		srx8    = 5'd9,
		srx16   = 5'd10,
		aluOp   = 5'd11,   // Operands taken from the opcode byte itself
		bitTest = 5'd12,
		sx8r    = 5'd13,
		sx16r   = 5'd14
	} uopCmd;

	// Bit 2 set means the rule may end the flow
	typedef enum logic [2:0]
	{
		endNever     = 3'd0,
		endAlways    = 3'd4,
		endIfZero    = 3'd5,
		endIfNotZero = 3'd7
	} endCond;

	typedef struct packed
	{
		logic           incPc;
		endCond         endRule;
		uopCmd          cmd;
		isaPkg::regCode operand;
	} uopWord;

	typedef enum logic [1:0]
	{
		afterReset,
		startFlow,
		runFlow,
		endFlow
	} seqState;

	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  writeData;
		logic        writeEnable;
	} busRequest;

	// --------------------------------------------------
	// Register file traffic
	typedef struct packed
	{
		logic           enable;
		isaPkg::regCode target;
		logic [15:0]    data;
	} regWriteReq;

	typedef struct packed
	{
		logic [15:0]     readValue;   // Value of the register picked by readSel
		logic [7:0]      a;
		logic [7:0]      x8;
		logic [15:0]     x16;
		isaPkg::flagBits flags;
	} regView;

endpackage

//--- verilog/isaPkg.sv
package isaPkg;

	// Register and pair selectors, shared by the read, write and address paths
	typedef enum logic [3:0]
	{
		codeB    = 4'd0,
		codeC    = 4'd1,
		codeD    = 4'd2,
		codeE    = 4'd3,
		codeH    = 4'd4,
		codeL    = 4'd5,
		codeHl   = 4'd6,
		codeA    = 4'd7,
		codePc   = 4'd8,
		codeSp   = 4'd9,
		codeX8   = 4'd10,
		codeX16  = 4'd11,
		codeBc   = 4'd12,   // Pair used by DEC BC
		codeNone = 4'd13,
		codeIoc  = 4'd14,   // High page I/O at FF00+C
		codeDe   = 4'd15
	} regCode;

	// Flags byte with Z on top, the low nibble is kept as written
	typedef struct packed
	{
		logic       z;
		logic       n;
		logic       h;
		logic       c;
		logic [3:0] spare;
	} flagBits;

	// Main opcode, 8-bit register codes in dst and src
	typedef struct packed
	{
		logic [1:0] group;
		logic [2:0] dst;
		logic [2:0] src;
	} mainOpcode;

	// Byte that follows a CB prefix
	typedef struct packed
	{
		logic [1:0] cbOp;
		logic [2:0] bitIndex;
		logic [2:0] target;
	} cbOperand;

	typedef union packed
	{
		mainOpcode main;
		cbOperand  cb;
	} opcodeWord;

endpackage
